//--- rtl/trap_pkg.sv
// trap operations, sequencer states and machine-mode trap constants
// only ECALL, MRET and the machine timer interrupt are handled

package trap_pkg;

  // decoded system operation, one per retiring instruction
  typedef enum logic [1:0] {
    OP_NONE  = 2'd0,
    OP_ECALL = 2'd1,
    OP_MRET  = 2'd2,
    OP_IRQ   = 2'd3
  } trap_op_e;

  // sequencer steps, entry path then return path
  typedef enum logic [3:0] {
    S_IDLE         = 4'd0,
    S_WR_MEPC      = 4'd1,
    S_WR_MCAUSE    = 4'd2,
    S_RD_MTVEC     = 4'd3,
    S_RD_MSTATUS_E = 4'd4,
    S_WR_MSTATUS_E = 4'd5,
    S_RD_MSTATUS_L = 4'd6,
    S_RD_MEPC      = 4'd7,
    S_WR_MSTATUS_L = 4'd8,
    S_JUMP         = 4'd9
  } seq_state_e;

  // full 32-bit system instruction words
  parameter logic [31:0] INST_ECALL = 32'h0000_0073;
  parameter logic [31:0] INST_MRET  = 32'h3020_0073;

  // exception codes without the interrupt bit
  // the sequencer adds bit XLEN-1 for interrupts
  parameter int unsigned CAUSE_ECALL_M = 11;  // environment call from M-mode
  parameter int unsigned CAUSE_TIMER   = 7;   // machine timer interrupt

endpackage

//--- rtl/csr_pkg.sv
// machine CSR addresses, mstatus field positions and the CSR access bundle
// only the four trap CSRs are defined

package csr_pkg;

  // 12-bit CSR addresses from the privileged spec
  parameter logic [11:0] CSR_MSTATUS = 12'h300;
  parameter logic [11:0] CSR_MTVEC   = 12'h305;
  parameter logic [11:0] CSR_MEPC    = 12'h341;
  parameter logic [11:0] CSR_MCAUSE  = 12'h342;

  // mstatus bit positions
  parameter int unsigned MSTATUS_MIE    = 3;   // global interrupt enable
  parameter int unsigned MSTATUS_MPIE   = 7;   // MIE before the trap
  parameter int unsigned MSTATUS_MPP_LO = 11;
  parameter int unsigned MSTATUS_MPP_HI = 12;  // previous privilege, 2 bits

  // one CSR access per cycle, ren and wen never together
  typedef struct packed {
    logic [11:0] addr;
    logic        ren;
    logic        wen;
  } csr_acc_t;

endpackage

//--- rtl/sys_decode.sv
// registered classifier for retiring instructions, one cycle latency
// i_irq only counts in a cycle with i_valid; no busy filtering here
`timescale 1ns/100ps

module sys_decode #(
  parameter int XLEN = 64
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                i_valid,
  input  logic [31:0]         i_inst,
  input  logic                i_irq,
  input  logic [XLEN-1:0]     i_pc,
  output trap_pkg::trap_op_e  o_op,
  output logic [XLEN-1:0]     o_pc
);

  trap_pkg::trap_op_e op_d;
  logic               is_ecall;
  logic               is_mret;

  assign is_ecall = (i_inst == trap_pkg::INST_ECALL);
  assign is_mret  = (i_inst == trap_pkg::INST_MRET);

  // interrupt wins over any instruction, even a system one
  always_comb begin
    if (i_irq) begin
      op_d = trap_pkg::OP_IRQ;
    end else if (is_ecall) begin
      op_d = trap_pkg::OP_ECALL;
    end else if (is_mret) begin
      op_d = trap_pkg::OP_MRET;
    end else begin
      op_d = trap_pkg::OP_NONE;
    end
  end

  // op is a single-cycle pulse
  always_ff @(posedge clk) begin
    if (rst) begin
      o_op <= trap_pkg::OP_NONE;
    end else if (i_valid) begin
      o_op <= op_d;
    end else begin
      o_op <= trap_pkg::OP_NONE;
    end
  end

  // pc only matters while o_op is not OP_NONE
  always_ff @(posedge clk) begin
    if (i_valid) begin
      o_pc <= i_pc;
    end
  end

endmodule

//--- rtl/trap_sequencer.sv
// steps through the CSR accesses for trap entry and mret, one access per cycle
// jump request is held until acked; ops arriving while not idle are dropped
`timescale 1ns/100ps

module trap_sequencer #(
  parameter int XLEN = 64
) (
  input  logic                clk,
  input  logic                rst,
  input  trap_pkg::trap_op_e  i_op,
  input  logic [XLEN-1:0]     i_pc,
  input  logic [XLEN-1:0]     i_rdata,
  input  logic                i_jmp_ack,
  output csr_pkg::csr_acc_t   o_acc,
  output logic [XLEN-1:0]     o_wdata,
  output logic                o_jmp_req,
  output logic [XLEN-1:0]     o_jmp_addr,
  output logic                o_busy
);

  trap_pkg::seq_state_e state;
  trap_pkg::seq_state_e state_d;

  logic            jmp_done;   // ack seen last cycle
  logic            accept;
  logic [XLEN-1:0] cause_q;
  logic [XLEN-1:0] pc_q;
  logic [XLEN-1:0] mstatus_q;  // copy read from the CSR file
  logic [XLEN-1:0] target_q;

  // MPP=M, MPIE<=MIE, MIE=0
  function automatic logic [XLEN-1:0] enter_mstatus(input logic [XLEN-1:0] s);
    logic [XLEN-1:0] r;
    r = s;
    r[csr_pkg::MSTATUS_MPP_HI:csr_pkg::MSTATUS_MPP_LO] = 2'b11;
    r[csr_pkg::MSTATUS_MPIE] = s[csr_pkg::MSTATUS_MIE];
    r[csr_pkg::MSTATUS_MIE]  = 1'b0;
    return r;
  endfunction

  // MIE<=MPIE, MPIE=1, MPP=U
  function automatic logic [XLEN-1:0] leave_mstatus(input logic [XLEN-1:0] s);
    logic [XLEN-1:0] r;
    r = s;
    r[csr_pkg::MSTATUS_MPP_HI:csr_pkg::MSTATUS_MPP_LO] = 2'b00;
    r[csr_pkg::MSTATUS_MPIE] = 1'b1;
    r[csr_pkg::MSTATUS_MIE]  = s[csr_pkg::MSTATUS_MPIE];
    return r;
  endfunction

  // an op right after the ack was strobed while still busy
  assign accept = (i_op != trap_pkg::OP_NONE) && !jmp_done;

  always_comb begin
    state_d = state;
    case (state)
      trap_pkg::S_IDLE: begin
        if (accept) begin
          if (i_op == trap_pkg::OP_MRET) begin
            state_d = trap_pkg::S_RD_MSTATUS_L;
          end else begin
            state_d = trap_pkg::S_WR_MEPC;
          end
        end
      end
      // entry path
      trap_pkg::S_WR_MEPC:      state_d = trap_pkg::S_WR_MCAUSE;
      trap_pkg::S_WR_MCAUSE:    state_d = trap_pkg::S_RD_MTVEC;
      trap_pkg::S_RD_MTVEC:     state_d = trap_pkg::S_RD_MSTATUS_E;
      trap_pkg::S_RD_MSTATUS_E: state_d = trap_pkg::S_WR_MSTATUS_E;
      trap_pkg::S_WR_MSTATUS_E: state_d = trap_pkg::S_JUMP;
      // return path
      trap_pkg::S_RD_MSTATUS_L: state_d = trap_pkg::S_RD_MEPC;
      trap_pkg::S_RD_MEPC:      state_d = trap_pkg::S_WR_MSTATUS_L;
      trap_pkg::S_WR_MSTATUS_L: state_d = trap_pkg::S_JUMP;
      trap_pkg::S_JUMP: begin
        if (i_jmp_ack) begin
          state_d = trap_pkg::S_IDLE;
        end
      end
      default: state_d = trap_pkg::S_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= trap_pkg::S_IDLE;
      jmp_done <= 1'b0;
    end else begin
      state    <= state_d;
      jmp_done <= (state == trap_pkg::S_JUMP) && i_jmp_ack;
    end
  end

  // payload captures, read data sampled in the same cycle as ren
  always_ff @(posedge clk) begin
    case (state)
      trap_pkg::S_IDLE: begin
        if (accept) begin
          pc_q <= i_pc;
          if (i_op == trap_pkg::OP_IRQ) begin
            cause_q <= {1'b1, (XLEN-1)'(trap_pkg::CAUSE_TIMER)};
          end else begin
            cause_q <= XLEN'(trap_pkg::CAUSE_ECALL_M);
          end
        end
      end
      trap_pkg::S_RD_MTVEC:     target_q  <= {i_rdata[XLEN-1:2], 2'b00};  // direct mode
      trap_pkg::S_RD_MSTATUS_E: mstatus_q <= i_rdata;
      trap_pkg::S_RD_MSTATUS_L: mstatus_q <= i_rdata;
      trap_pkg::S_RD_MEPC:      target_q  <= i_rdata;
      default: ;
    endcase
  end

  // CSR access decoded straight from the state
  always_comb begin
    o_acc   = '0;
    o_wdata = '0;
    case (state)
      trap_pkg::S_WR_MEPC: begin
        o_acc.addr = csr_pkg::CSR_MEPC;
        o_acc.wen  = 1'b1;
        o_wdata    = pc_q;
      end
      trap_pkg::S_WR_MCAUSE: begin
        o_acc.addr = csr_pkg::CSR_MCAUSE;
        o_acc.wen  = 1'b1;
        o_wdata    = cause_q;
      end
      trap_pkg::S_RD_MTVEC: begin
        o_acc.addr = csr_pkg::CSR_MTVEC;
        o_acc.ren  = 1'b1;
      end
      trap_pkg::S_RD_MSTATUS_E, trap_pkg::S_RD_MSTATUS_L: begin
        o_acc.addr = csr_pkg::CSR_MSTATUS;
        o_acc.ren  = 1'b1;
      end
      trap_pkg::S_WR_MSTATUS_E: begin
        o_acc.addr = csr_pkg::CSR_MSTATUS;
        o_acc.wen  = 1'b1;
        o_wdata    = enter_mstatus(mstatus_q);
      end
      trap_pkg::S_RD_MEPC: begin
        o_acc.addr = csr_pkg::CSR_MEPC;
        o_acc.ren  = 1'b1;
      end
      trap_pkg::S_WR_MSTATUS_L: begin
        o_acc.addr = csr_pkg::CSR_MSTATUS;
        o_acc.wen  = 1'b1;
        o_wdata    = leave_mstatus(mstatus_q);
      end
      default: ;
    endcase
  end

  assign o_jmp_req  = (state == trap_pkg::S_JUMP);
  assign o_jmp_addr = target_q;   // stable through S_JUMP
  assign o_busy     = (state != trap_pkg::S_IDLE) || accept;

endmodule

//--- rtl/csr_file.sv
// mstatus, mepc, mcause and mtvec; unknown addresses read 0 and drop writes
// outside writes only land while i_busy is low, sequencer writes win
`timescale 1ns/100ps

module csr_file #(
  parameter int XLEN = 64
) (
  input  logic              clk,
  input  logic              rst,
  input  csr_pkg::csr_acc_t i_acc,
  input  logic [XLEN-1:0]   i_wdata,
  input  logic              i_busy,
  input  logic              i_ext_wen,
  input  logic [11:0]       i_ext_addr,
  input  logic [XLEN-1:0]   i_ext_wdata,
  input  logic [11:0]       i_ext_raddr,
  output logic [XLEN-1:0]   o_rdata,
  output logic [XLEN-1:0]   o_ext_rdata
);

  logic [XLEN-1:0] mstatus;
  logic [XLEN-1:0] mepc;
  logic [XLEN-1:0] mcause;
  logic [XLEN-1:0] mtvec;

  logic            wr_en;
  logic [11:0]     wr_addr;
  logic [XLEN-1:0] wr_data;

  function automatic logic [XLEN-1:0] read_csr(input logic [11:0] addr);
    case (addr)
      csr_pkg::CSR_MSTATUS: return mstatus;
      csr_pkg::CSR_MEPC:    return mepc;
      csr_pkg::CSR_MCAUSE:  return mcause;
      csr_pkg::CSR_MTVEC:   return mtvec;
      default:              return '0;
    endcase
  endfunction

  // single write port, sequencer first
  always_comb begin
    if (i_acc.wen) begin
      wr_en   = 1'b1;
      wr_addr = i_acc.addr;
      wr_data = i_wdata;
    end else begin
      wr_en   = i_ext_wen && !i_busy;  // busy writes are lost
      wr_addr = i_ext_addr;
      wr_data = i_ext_wdata;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      mstatus <= XLEN'(1) << csr_pkg::MSTATUS_MIE;  // interrupts on
      mepc    <= '0;
      mcause  <= '0;
      mtvec   <= '0;
    end else if (wr_en) begin
      case (wr_addr)
        csr_pkg::CSR_MSTATUS: mstatus <= wr_data;
        csr_pkg::CSR_MEPC:    mepc    <= wr_data;
        csr_pkg::CSR_MCAUSE:  mcause  <= wr_data;
        csr_pkg::CSR_MTVEC:   mtvec   <= wr_data;  // mode bits kept as written
        default: ;
      endcase
    end
  end

  // same-cycle read for the sequencer
  assign o_rdata     = i_acc.ren ? read_csr(i_acc.addr) : '0;
  assign o_ext_rdata = read_csr(i_ext_raddr);

endmodule

//--- rtl/trap_unit_top.sv
// machine-mode trap unit: decode, CSR sequencer and CSR file
// ack may be held off indefinitely; o_jmp_addr holds while o_jmp_req is high
`timescale 1ns/100ps

module trap_unit_top #(
  parameter int XLEN = 64
) (
  input  logic            clk,
  input  logic            rst,
  input  logic            i_valid,
  input  logic [31:0]     i_inst,
  input  logic            i_irq,
  input  logic [XLEN-1:0] i_pc,
  output logic            o_jmp_req,
  input  logic            i_jmp_ack,
  output logic [XLEN-1:0] o_jmp_addr,
  output logic            o_busy,
  input  logic            i_csr_wen,
  input  logic [11:0]     i_csr_addr,
  input  logic [XLEN-1:0] i_csr_wdata,
  input  logic [11:0]     i_csr_raddr,
  output logic [XLEN-1:0] o_csr_rdata
);

  trap_pkg::trap_op_e op;
  logic [XLEN-1:0]    op_pc;
  csr_pkg::csr_acc_t  acc;
  logic [XLEN-1:0]    acc_wdata;
  logic [XLEN-1:0]    acc_rdata;

  sys_decode #(.XLEN(XLEN)) u_decode (
    .clk     (clk),
    .rst     (rst),
    .i_valid (i_valid),
    .i_inst  (i_inst),
    .i_irq   (i_irq),
    .i_pc    (i_pc),
    .o_op    (op),
    .o_pc    (op_pc)
  );

  trap_sequencer #(.XLEN(XLEN)) u_seq (
    .clk        (clk),
    .rst        (rst),
    .i_op       (op),
    .i_pc       (op_pc),
    .i_rdata    (acc_rdata),
    .i_jmp_ack  (i_jmp_ack),
    .o_acc      (acc),
    .o_wdata    (acc_wdata),
    .o_jmp_req  (o_jmp_req),
    .o_jmp_addr (o_jmp_addr),
    .o_busy     (o_busy)
  );

  // busy also blocks outside CSR writes
  csr_file #(.XLEN(XLEN)) u_csr (
    .clk         (clk),
    .rst         (rst),
    .i_acc       (acc),
    .i_wdata     (acc_wdata),
    .i_busy      (o_busy),
    .i_ext_wen   (i_csr_wen),
    .i_ext_addr  (i_csr_addr),
    .i_ext_wdata (i_csr_wdata),
    .i_ext_raddr (i_csr_raddr),
    .o_rdata     (acc_rdata),
    .o_ext_rdata (o_csr_rdata)
  );

endmodule

//--- verif/trap_unit_props.sv
// properties bound into every trap_sequencer instance
// idle busy is checked in the cycle after the jump, where a late op may arrive
`timescale 1ns/100ps

module trap_unit_props (
  input logic                 i_clk,
  input logic                 i_rst,
  input trap_pkg::seq_state_e i_state,
  input csr_pkg::csr_acc_t    i_acc,
  input logic                 i_jmp_req,
  input logic                 i_jmp_ack,
  input logic                 i_busy
);

  property req_held_until_ack;
    @(posedge i_clk) disable iff (i_rst) (i_jmp_req && !i_jmp_ack) |=> i_jmp_req;
  endproperty

  // every access state lasts one cycle, so no access repeats
  property one_cycle_access;
    @(posedge i_clk) disable iff (i_rst)
      (i_acc.ren || i_acc.wen) |=> (i_acc != $past(i_acc));
  endproperty

  property idle_not_busy;
    @(posedge i_clk) disable iff (i_rst)
      (i_state == trap_pkg::S_IDLE && $past(i_jmp_req)) |-> !i_busy;
  endproperty

  assert property (req_held_until_ack) else $error("jump request dropped before ack");
  assert property (one_cycle_access) else $error("CSR access held for more than one cycle");
  assert property (idle_not_busy) else $error("busy high while sequencer idle");

endmodule

bind trap_sequencer trap_unit_props u_props (
  .i_clk     (clk),
  .i_rst     (rst),
  .i_state   (state),
  .i_acc     (o_acc),
  .i_jmp_req (o_jmp_req),
  .i_jmp_ack (i_jmp_ack),
  .i_busy    (o_busy)
);

//--- verif/trap_unit_tb.sv
// testbench for trap_unit_top with XLEN 64; the CSR model follows the mstatus rules
// every wait gives up after 50 cycles
`timescale 1ns/100ps

module trap_unit_tb;

  typedef struct packed {
    logic [63:0] mstatus;
    logic [63:0] mepc;
    logic [63:0] mcause;
    logic [63:0] mtvec;
  } csr_shadow_t;

  localparam logic [31:0] INST_ADDI = 32'h00a0_0093;  // ordinary instruction

  logic        clk;
  logic        rst;
  logic        i_valid;
  logic [31:0] i_inst;
  logic        i_irq;
  logic [63:0] i_pc;
  logic        o_jmp_req;
  logic        i_jmp_ack;
  logic [63:0] o_jmp_addr;
  logic        o_busy;
  logic        i_csr_wen;
  logic [11:0] i_csr_addr;
  logic [63:0] i_csr_wdata;
  logic [11:0] i_csr_raddr;
  logic [63:0] o_csr_rdata;

  logic [31:0] seed;
  csr_shadow_t shadow;
  logic [63:0] exp_jmp;
  logic        exp_armed;
  logic [63:0] held_addr;
  logic        req_seen;
  string       cur_test;
  int          test_err;
  int          total_err;
  int          test_cnt;
  int          fail_cnt;

  trap_unit_top #(.XLEN(64)) dut0 (
    .clk         (clk),
    .rst         (rst),
    .i_valid     (i_valid),
    .i_inst      (i_inst),
    .i_irq       (i_irq),
    .i_pc        (i_pc),
    .o_jmp_req   (o_jmp_req),
    .i_jmp_ack   (i_jmp_ack),
    .o_jmp_addr  (o_jmp_addr),
    .o_busy      (o_busy),
    .i_csr_wen   (i_csr_wen),
    .i_csr_addr  (i_csr_addr),
    .i_csr_wdata (i_csr_wdata),
    .i_csr_raddr (i_csr_raddr),
    .o_csr_rdata (o_csr_rdata)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  function automatic logic [31:0] lcg_next();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  function automatic logic [63:0] rand64();
    logic [63:0] v;
    v[63:32] = lcg_next();
    v[31:0]  = lcg_next();
    return v;
  endfunction

  // expected jump target and CSR state after one operation
  function automatic logic [63:0] model_step(input trap_pkg::trap_op_e op,
                                             input logic [63:0] pc,
                                             input csr_shadow_t cur,
                                             output csr_shadow_t nxt);
    logic [63:0] s;
    logic [63:0] addr;
    nxt  = cur;
    s    = cur.mstatus;
    addr = '0;
    case (op)
      trap_pkg::OP_ECALL, trap_pkg::OP_IRQ: begin
        nxt.mepc = pc;
        if (op == trap_pkg::OP_IRQ) begin
          nxt.mcause = {1'b1, 63'(trap_pkg::CAUSE_TIMER)};
        end else begin
          nxt.mcause = 64'(trap_pkg::CAUSE_ECALL_M);
        end
        s[csr_pkg::MSTATUS_MPP_HI:csr_pkg::MSTATUS_MPP_LO] = 2'b11;
        s[csr_pkg::MSTATUS_MPIE] = cur.mstatus[csr_pkg::MSTATUS_MIE];
        s[csr_pkg::MSTATUS_MIE]  = 1'b0;
        addr = {cur.mtvec[63:2], 2'b00};
      end
      trap_pkg::OP_MRET: begin
        s[csr_pkg::MSTATUS_MIE]  = cur.mstatus[csr_pkg::MSTATUS_MPIE];
        s[csr_pkg::MSTATUS_MPIE] = 1'b1;
        s[csr_pkg::MSTATUS_MPP_HI:csr_pkg::MSTATUS_MPP_LO] = 2'b00;
        addr = cur.mepc;
      end
      default: ;
    endcase
    nxt.mstatus = s;
    return addr;
  endfunction

  task automatic note_error();
    test_err++;
    total_err++;
  endtask

  task automatic start_test(input string name);
    cur_test = name;
    test_err = 0;
  endtask

  task automatic end_test();
    test_cnt++;
    if (test_err != 0) begin
      fail_cnt++;
    end
    $display("[%s] %0d errors", cur_test, test_err);
  endtask

  // comparison of the jump request, sampled on the falling edge
  always @(negedge clk) begin
    if (!rst && o_jmp_req) begin
      if (!req_seen) begin
        assert (exp_armed) else begin
          $display("unexpected jump request in %s", cur_test);
          note_error();
        end
        assert (o_jmp_addr == exp_jmp) else begin
          $display("MISMATCH %s jmp_addr expected %h actual %h", cur_test, exp_jmp, o_jmp_addr);
          note_error();
        end
        held_addr = o_jmp_addr;
      end else begin
        assert (o_jmp_addr == held_addr) else begin
          $display("MISMATCH %s held jmp_addr expected %h actual %h",
                   cur_test, held_addr, o_jmp_addr);
          note_error();
        end
      end
    end
    req_seen = o_jmp_req;
  end

  task automatic wait_req();
    int n;
    n = 0;
    while (!o_jmp_req && n < 50) begin
      @(negedge clk);
      n++;
    end
    if (!o_jmp_req) begin
      $display("timeout: no jump request within 50 cycles in %s", cur_test);
      $display("test failed");
      $finish;
    end
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    while (o_busy && n < 50) begin
      @(negedge clk);
      n++;
    end
    if (o_busy) begin
      $display("timeout: unit still busy after 50 cycles in %s", cur_test);
      $display("test failed");
      $finish;
    end
  endtask

  // read port driven on one falling edge, sampled on the next
  task automatic check_one(input string field, input logic [11:0] addr, input logic [63:0] exp);
    i_csr_raddr = addr;
    @(negedge clk);
    assert (o_csr_rdata == exp) else begin
      $display("MISMATCH %s %s expected %h actual %h", cur_test, field, exp, o_csr_rdata);
      note_error();
    end
  endtask

  task automatic check_csrs();
    check_one("mstatus", csr_pkg::CSR_MSTATUS, shadow.mstatus);
    check_one("mepc", csr_pkg::CSR_MEPC, shadow.mepc);
    check_one("mcause", csr_pkg::CSR_MCAUSE, shadow.mcause);
    check_one("mtvec", csr_pkg::CSR_MTVEC, shadow.mtvec);
  endtask

  task automatic csr_write(input logic [11:0] addr, input logic [63:0] data);
    i_csr_wen   = 1'b1;
    i_csr_addr  = addr;
    i_csr_wdata = data;
    @(negedge clk);
    i_csr_wen = 1'b0;
    case (addr)
      csr_pkg::CSR_MSTATUS: shadow.mstatus = data;
      csr_pkg::CSR_MEPC:    shadow.mepc    = data;
      csr_pkg::CSR_MCAUSE:  shadow.mcause  = data;
      csr_pkg::CSR_MTVEC:   shadow.mtvec   = data;
      default: ;
    endcase
  endtask

  // ECALL strobe and mtvec write, both to be ignored while busy
  task automatic drive_busy_noise();
    i_valid     = 1'b1;
    i_inst      = trap_pkg::INST_ECALL;
    i_pc        = rand64();
    i_csr_wen   = 1'b1;
    i_csr_addr  = csr_pkg::CSR_MTVEC;
    i_csr_wdata = rand64();
  endtask

  // one retiring instruction, ack after ack_delay cycles; noise strobes and writes while busy
  task automatic run_op(input logic [31:0] inst, input logic irq, input logic [63:0] pc,
                        input int ack_delay, input logic noise);
    trap_pkg::trap_op_e op;
    csr_shadow_t        nxt;
    int                 i;
    if (irq) begin
      op = trap_pkg::OP_IRQ;
    end else if (inst == trap_pkg::INST_ECALL) begin
      op = trap_pkg::OP_ECALL;
    end else if (inst == trap_pkg::INST_MRET) begin
      op = trap_pkg::OP_MRET;
    end else begin
      op = trap_pkg::OP_NONE;
    end
    exp_jmp   = model_step(op, pc, shadow, nxt);
    exp_armed = (op != trap_pkg::OP_NONE);
    i_valid = 1'b1;
    i_inst  = inst;
    i_irq   = irq;
    i_pc    = pc;
    @(negedge clk);
    i_valid = 1'b0;
    i_irq   = 1'b0;
    if (op == trap_pkg::OP_NONE) begin
      for (i = 0; i < 10; i++) begin
        @(negedge clk);
        assert (!o_busy) else begin
          $display("unit went busy on a non-system instruction in %s", cur_test);
          note_error();
        end
      end
    end else begin
      wait_req();
      for (i = 0; i < ack_delay; i++) begin
        if (noise) begin
          drive_busy_noise();
        end
        @(negedge clk);
        i_valid   = 1'b0;
        i_csr_wen = 1'b0;
      end
      if (noise) begin
        drive_busy_noise();  // also in the ack cycle
      end
      i_jmp_ack = 1'b1;
      @(negedge clk);
      i_jmp_ack = 1'b0;
      i_valid   = 1'b0;
      i_csr_wen = 1'b0;
      exp_armed = 1'b0;
      wait_idle();
    end
    shadow = nxt;
    check_csrs();
  endtask

  initial begin
    logic [31:0] r;
    logic [31:0] w;
    int          k;
    seed        = 32'h2c2515f7;
    rst         = 1'b1;
    i_valid     = 1'b0;
    i_inst      = '0;
    i_irq       = 1'b0;
    i_pc        = '0;
    i_jmp_ack   = 1'b0;
    i_csr_wen   = 1'b0;
    i_csr_addr  = '0;
    i_csr_wdata = '0;
    i_csr_raddr = '0;
    exp_jmp     = '0;
    exp_armed   = 1'b0;
    held_addr   = '0;
    req_seen    = 1'b0;
    test_err    = 0;
    total_err   = 0;
    test_cnt    = 0;
    fail_cnt    = 0;
    cur_test    = "reset";
    shadow      = '{mstatus: 64'h8, mepc: '0, mcause: '0, mtvec: '0};
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    start_test("reset");
    assert (!o_busy && !o_jmp_req) else begin
      $display("busy or jump request high after reset");
      note_error();
    end
    check_csrs();
    end_test();

    start_test("ecall_entry");
    csr_write(csr_pkg::CSR_MTVEC, rand64());
    run_op(trap_pkg::INST_ECALL, 1'b0, rand64(), 0, 1'b0);
    end_test();

    start_test("mret_return");
    run_op(trap_pkg::INST_MRET, 1'b0, rand64(), 0, 1'b0);
    end_test();

    start_test("timer_irq");
    run_op(INST_ADDI, 1'b1, rand64(), 1, 1'b0);
    run_op(trap_pkg::INST_MRET, 1'b0, rand64(), 0, 1'b0);
    run_op(trap_pkg::INST_ECALL, 1'b1, rand64(), 0, 1'b0);
    end_test();

    start_test("back_pressure");
    csr_write(csr_pkg::CSR_MTVEC, rand64());
    run_op(trap_pkg::INST_ECALL, 1'b0, rand64(), 3 + int'(lcg_next() % 8), 1'b1);
    run_op(trap_pkg::INST_MRET, 1'b0, rand64(), 3 + int'(lcg_next() % 8), 1'b1);
    end_test();

    start_test("non_system");
    run_op(INST_ADDI, 1'b0, rand64(), 0, 1'b0);
    end_test();

    start_test("random_seq");
    for (k = 0; k < 200; k++) begin
      r = lcg_next();
      w = lcg_next();  // ordinary instruction bits
      if (r[4:2] == 3'd0) begin
        csr_write(csr_pkg::CSR_MTVEC, rand64());
      end
      case (r[1:0])
        2'd0: run_op(trap_pkg::INST_ECALL, 1'b0, rand64(), int'(r[9:8]), r[10]);
        2'd1: run_op(trap_pkg::INST_MRET, 1'b0, rand64(), int'(r[9:8]), r[10]);
        2'd2: run_op({w[31:7], 7'h13}, 1'b1, rand64(), int'(r[9:8]), r[10]);
        default: run_op({w[31:7], 7'h13}, 1'b0, rand64(), 0, 1'b0);
      endcase
    end
    end_test();

    $display("tests %0d, failed %0d, errors %0d", test_cnt, fail_cnt, total_err);
    if (total_err == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

//--- vlog.f
rtl/trap_pkg.sv
rtl/csr_pkg.sv
rtl/sys_decode.sv
rtl/trap_sequencer.sv
rtl/csr_file.sv
rtl/trap_unit_top.sv
verif/trap_unit_props.sv
verif/trap_unit_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module trap_unit_tb -f vlog.f -o trap_unit_sim

if ! ./obj_dir/trap_unit_sim > sim.log 2>&1; then
  cat sim.log
  echo "simulation exited with an error"
  exit 1
fi
cat sim.log

if grep -q "test failed" sim.log; then
  exit 1
fi
exit 0
